// ==== hw/barrel_pkg.sv ====
package barrel_pkg;

    // ---------------------------------------------------------------------------
    // core dimensions
    // ---------------------------------------------------------------------------

    localparam int threads        = 4;
    localparam int id_bits        = 2;
    localparam int pc_bits        = 32;
    localparam int word_bits      = 32;
    localparam int imem_words     = 256;
    localparam int imem_addr_bits = 8;
    localparam int reg_count      = 8;
    localparam int reg_bits       = 3;
    localparam int imm_bits       = 19;
    // each thread owns 64 words of code
    localparam int thread_span    = 256;

    typedef logic [id_bits-1:0]        id_t;
    typedef logic [pc_bits-1:0]        pc_t;
    typedef logic [word_bits-1:0]      word_t;
    typedef logic [imem_addr_bits-1:0] imem_addr_t;
    typedef logic [reg_bits-1:0]       reg_t;

    function automatic pc_t thread_base_pc(input id_t id);
        return pc_t'(id) * pc_t'(thread_span);
    endfunction

    // ---------------------------------------------------------------------------
    // instruction encoding
    // ---------------------------------------------------------------------------

    // codes 10..15 are no-ops that still retire
    typedef enum logic [3:0] {
        op_add  = 4'h0,
        op_sub  = 4'h1,
        op_and  = 4'h2,
        op_or   = 4'h3,
        op_xor  = 4'h4,
        op_addi = 4'h5,
        op_lui  = 4'h6,
        op_bnz  = 4'h7,
        op_halt = 4'h8,
        op_wake = 4'h9
    } opcode_e;

    typedef struct packed {
        opcode_e     opcode;
        reg_t        rd;
        reg_t        rs1;
        reg_t        rs2;
        logic [18:0] pad;
    } r_fmt_t;

    typedef struct packed {
        opcode_e                    opcode;
        reg_t                       rd;
        reg_t                       rs1;
        logic [2:0]                 spare;
        logic signed [imm_bits-1:0] imm;
    } i_fmt_t;

    // opcode, rd and rs1 share their bits in both views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    // ---------------------------------------------------------------------------
    // pipeline records
    // ---------------------------------------------------------------------------

    typedef struct packed {
        id_t  id;
        logic phase;
        pc_t  pc;
        logic valid;
    } fetch_t;

    typedef struct packed {
        id_t     id;
        logic    phase;
        pc_t     pc;
        opcode_e opcode;
        reg_t    rd;
        word_t   a;
        word_t   b;
        word_t   imm;
        logic    valid;
    } dec_t;

    typedef struct packed {
        id_t     id;
        pc_t     pc;
        opcode_e opcode;
        logic    wb_en;
        reg_t    rd;
        word_t   value;
        logic    taken;
        logic    valid;
    } retire_t;

    typedef struct packed {
        id_t  id;
        pc_t  pc;
        logic valid;
    } redirect_t;

    typedef struct packed {
        id_t  id;
        logic valid;
    } thread_ctl_t;

endpackage

// ==== hw/thread_pc.sv ====
`timescale 1ns/1ps

module thread_pc (
    input  logic                    clk,
    input  logic                    reset,
    input  barrel_pkg::thread_ctl_t start_req,
    input  barrel_pkg::thread_ctl_t wake,
    input  barrel_pkg::thread_ctl_t halt,
    input  barrel_pkg::redirect_t   redirect,
    input  logic                    advance,
    output barrel_pkg::fetch_t      fetch
);

    logic [barrel_pkg::threads-1:0]             run;
    logic [barrel_pkg::threads-1:0]             run_nxt;
    logic [barrel_pkg::threads-1:0]             phase;
    logic [barrel_pkg::threads-1:0]             phase_nxt;
    barrel_pkg::pc_t [barrel_pkg::threads-1:0]  pc;
    barrel_pkg::pc_t [barrel_pkg::threads-1:0]  pc_nxt;
    barrel_pkg::id_t                            slot;
    barrel_pkg::fetch_t                         fetch_nxt;

    // ---------------------------------------------------------------------------
    // run control
    // ---------------------------------------------------------------------------

    // wake and start are applied after halt so a set beats a clear
    always_comb begin
        run_nxt = run;
        if (advance && halt.valid) begin
            run_nxt[halt.id] = 1'b0;
        end
        if (advance && wake.valid) begin
            run_nxt[wake.id] = 1'b1;
        end
        if (start_req.valid) begin
            run_nxt[start_req.id] = 1'b1;
        end
    end

    // ---------------------------------------------------------------------------
    // program counters and slot
    // ---------------------------------------------------------------------------

    always_comb begin
        pc_nxt    = pc;
        phase_nxt = phase;

        // redirect lands in the same cycle its thread owns the slot
        if (advance && redirect.valid) begin
            pc_nxt[redirect.id]    = redirect.pc;
            phase_nxt[redirect.id] = ~phase[redirect.id];
        end

        fetch_nxt.id    = slot;
        fetch_nxt.phase = phase_nxt[slot];
        fetch_nxt.pc    = pc_nxt[slot];
        fetch_nxt.valid = run_nxt[slot];

        // stopped thread gives a bubble and keeps its pc
        if (run_nxt[slot]) begin
            pc_nxt[slot] = pc_nxt[slot] + barrel_pkg::pc_t'(4);
        end
    end

    always_ff @(posedge clk) begin
        run <= run_nxt;
        if (advance) begin
            pc    <= pc_nxt;
            phase <= phase_nxt;
            slot  <= slot + barrel_pkg::id_t'(1);
            fetch <= fetch_nxt;
        end
        if (reset) begin
            run         <= '0;
            phase       <= '0;
            slot        <= '0;
            fetch.valid <= 1'b0;
            for (int i = 0; i < barrel_pkg::threads; i++) begin
                pc[i] <= barrel_pkg::thread_base_pc(barrel_pkg::id_t'(i));
            end
        end
    end

endmodule

// ==== hw/instr_mem.sv ====
`timescale 1ns/1ps

module instr_mem (
    input  logic                   clk,
    input  logic                   load_valid,
    input  barrel_pkg::imem_addr_t load_addr,
    input  barrel_pkg::word_t      load_data,
    input  logic                   advance,
    input  barrel_pkg::pc_t        rd_pc,
    output barrel_pkg::instr_u     instr
);

    barrel_pkg::word_t      mem [barrel_pkg::imem_words];
    barrel_pkg::imem_addr_t rd_index;

    // word index of the fetch pc
    assign rd_index = rd_pc[barrel_pkg::imem_addr_bits+1:2];

    // load port writes one word per cycle
    always_ff @(posedge clk) begin
        if (load_valid) begin
            mem[load_addr] <= load_data;
        end
    end

    // read port follows the pipeline and holds on a stall
    always_ff @(posedge clk) begin
        if (advance) begin
            instr <= mem[rd_index];
        end
    end

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               advance,
    input  barrel_pkg::fetch_t fetch,
    input  barrel_pkg::instr_u instr,
    input  logic               wr_en,
    input  barrel_pkg::id_t    wr_id,
    input  barrel_pkg::reg_t   wr_rd,
    input  barrel_pkg::word_t  wr_value,
    output barrel_pkg::dec_t   dec
);

    localparam int ext_bits = barrel_pkg::word_bits - barrel_pkg::imm_bits;

    barrel_pkg::fetch_t fetch_d;
    barrel_pkg::word_t  regs [barrel_pkg::threads][barrel_pkg::reg_count];
    logic               is_imm;
    barrel_pkg::word_t  rs1_val;
    barrel_pkg::word_t  rs2_val;
    barrel_pkg::word_t  imm_ext;
    barrel_pkg::dec_t   dec_nxt;

    // ---------------------------------------------------------------------------
    // per-thread register file of 8 registers
    // ---------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int t = 0; t < barrel_pkg::threads; t++) begin
                for (int r = 0; r < barrel_pkg::reg_count; r++) begin
                    regs[t][r] <= '0;
                end
            end
        end else if (wr_en) begin
            regs[wr_id][wr_rd] <= wr_value;
        end
    end

    // ---------------------------------------------------------------------------
    // field split and operand select
    // ---------------------------------------------------------------------------

    always_comb begin
        case (instr.r.opcode)
            barrel_pkg::op_addi,
            barrel_pkg::op_lui,
            barrel_pkg::op_bnz,
            barrel_pkg::op_wake: is_imm = 1'b1;
            default:             is_imm = 1'b0;
        endcase

        imm_ext = {{ext_bits{instr.i.imm[barrel_pkg::imm_bits-1]}}, instr.i.imm};

        // r0 reads as zero
        rs1_val = (instr.r.rs1 == '0) ? '0 : regs[fetch_d.id][instr.r.rs1];
        rs2_val = (instr.r.rs2 == '0) ? '0 : regs[fetch_d.id][instr.r.rs2];

        dec_nxt.id     = fetch_d.id;
        dec_nxt.phase  = fetch_d.phase;
        dec_nxt.pc     = fetch_d.pc;
        dec_nxt.opcode = instr.r.opcode;
        dec_nxt.rd     = instr.r.rd;
        dec_nxt.a      = rs1_val;
        dec_nxt.b      = is_imm ? imm_ext : rs2_val;
        dec_nxt.imm    = imm_ext;
        dec_nxt.valid  = fetch_d.valid;
    end

    // fetch_d lines up with the memory word
    always_ff @(posedge clk) begin
        if (advance) begin
            fetch_d <= fetch;
            dec     <= dec_nxt;
        end
        if (reset) begin
            fetch_d.valid <= 1'b0;
            dec.valid     <= 1'b0;
        end
    end

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    advance,
    input  barrel_pkg::dec_t        dec,
    output barrel_pkg::retire_t     exe,
    output barrel_pkg::redirect_t   redirect,
    output barrel_pkg::thread_ctl_t wake,
    output barrel_pkg::thread_ctl_t halt
);

    localparam int lui_pad = barrel_pkg::word_bits - barrel_pkg::imm_bits;

    logic [barrel_pkg::threads-1:0] phase_q;
    logic                           live;
    logic                           taken;
    logic                           writes;
    barrel_pkg::word_t              value;
    barrel_pkg::pc_t                target;

    // ---------------------------------------------------------------------------
    // ALU and branch decision
    // ---------------------------------------------------------------------------

    always_comb begin
        // stale phase means wrong path after a taken branch
        live   = dec.valid && (dec.phase == phase_q[dec.id]);
        taken  = 1'b0;
        writes = 1'b0;
        value  = '0;
        target = dec.pc + {dec.imm[barrel_pkg::pc_bits-3:0], 2'b00};

        case (dec.opcode)
            barrel_pkg::op_add: begin
                value  = dec.a + dec.b;
                writes = 1'b1;
            end
            barrel_pkg::op_sub: begin
                value  = dec.a - dec.b;
                writes = 1'b1;
            end
            barrel_pkg::op_and: begin
                value  = dec.a & dec.b;
                writes = 1'b1;
            end
            barrel_pkg::op_or: begin
                value  = dec.a | dec.b;
                writes = 1'b1;
            end
            barrel_pkg::op_xor: begin
                value  = dec.a ^ dec.b;
                writes = 1'b1;
            end
            barrel_pkg::op_addi: begin
                value  = dec.a + dec.b;
                writes = 1'b1;
            end
            barrel_pkg::op_lui: begin
                value  = {dec.imm[barrel_pkg::imm_bits-1:0], {lui_pad{1'b0}}};
                writes = 1'b1;
            end
            barrel_pkg::op_bnz: begin
                // value carries the thread's next pc
                taken = (dec.a != '0);
                value = taken ? target : dec.pc + barrel_pkg::pc_t'(4);
            end
            default: begin
            end
        endcase
    end

    // ---------------------------------------------------------------------------
    // execute register and thread requests
    // ---------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (advance) begin
            exe.id     <= dec.id;
            exe.pc     <= dec.pc;
            exe.opcode <= dec.opcode;
            exe.wb_en  <= writes && (dec.rd != '0);
            exe.rd     <= dec.rd;
            exe.value  <= value;
            exe.taken  <= taken;
            exe.valid  <= live;

            redirect.id    <= dec.id;
            redirect.pc    <= target;
            redirect.valid <= live && taken;

            wake.id    <= dec.imm[barrel_pkg::id_bits-1:0];
            wake.valid <= live && (dec.opcode == barrel_pkg::op_wake);
            halt.id    <= dec.id;
            halt.valid <= live && (dec.opcode == barrel_pkg::op_halt);

            if (live && taken) begin
                phase_q[dec.id] <= ~phase_q[dec.id];
            end
        end
        if (reset) begin
            phase_q        <= '0;
            exe.valid      <= 1'b0;
            redirect.valid <= 1'b0;
            wake.valid     <= 1'b0;
            halt.valid     <= 1'b0;
        end
    end

endmodule

// ==== hw/result_stage.sv ====
`timescale 1ns/1ps

module result_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                advance,
    input  barrel_pkg::retire_t exe,
    output logic                wr_en,
    output barrel_pkg::id_t     wr_id,
    output barrel_pkg::reg_t    wr_rd,
    output barrel_pkg::word_t   wr_value,
    output barrel_pkg::retire_t retire,
    output logic                retire_valid
);

    // ---------------------------------------------------------------------------
    // register file write
    // ---------------------------------------------------------------------------

    // write lands on the edge the record moves into the retire register
    assign wr_en    = advance && exe.valid && exe.wb_en && (exe.rd != '0);
    assign wr_id    = exe.id;
    assign wr_rd    = exe.rd;
    assign wr_value = exe.value;

    // ---------------------------------------------------------------------------
    // retire output register
    // ---------------------------------------------------------------------------

    // holds its record while the port stalls
    always_ff @(posedge clk) begin
        if (advance) begin
            retire <= exe;
        end
        if (reset) begin
            retire.valid <= 1'b0;
        end
    end

    assign retire_valid = retire.valid;

endmodule

// ==== hw/barrel_core.sv ====
`timescale 1ns/1ps

module barrel_core (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    load_valid,
    input  barrel_pkg::imem_addr_t  load_addr,
    input  barrel_pkg::word_t       load_data,
    input  barrel_pkg::thread_ctl_t start_req,
    output barrel_pkg::retire_t     retire,
    output logic                    retire_valid,
    input  logic                    retire_ready
);

    logic                    advance;
    barrel_pkg::fetch_t      fetch;
    barrel_pkg::instr_u      instr;
    barrel_pkg::dec_t        dec;
    barrel_pkg::retire_t     exe;
    barrel_pkg::redirect_t   redirect;
    barrel_pkg::thread_ctl_t wake;
    barrel_pkg::thread_ctl_t halt;
    logic                    wr_en;
    barrel_pkg::id_t         wr_id;
    barrel_pkg::reg_t        wr_rd;
    barrel_pkg::word_t       wr_value;

    // whole pipeline moves together and holds only on a stuck retire record
    assign advance = !retire_valid || retire_ready;

    thread_pc u_thread_pc (
        .clk       (clk),
        .reset     (reset),
        .start_req (start_req),
        .wake      (wake),
        .halt      (halt),
        .redirect  (redirect),
        .advance   (advance),
        .fetch     (fetch)
    );

    instr_mem u_instr_mem (
        .clk        (clk),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .advance    (advance),
        .rd_pc      (fetch.pc),
        .instr      (instr)
    );

    decode_stage u_decode_stage (
        .clk      (clk),
        .reset    (reset),
        .advance  (advance),
        .fetch    (fetch),
        .instr    (instr),
        .wr_en    (wr_en),
        .wr_id    (wr_id),
        .wr_rd    (wr_rd),
        .wr_value (wr_value),
        .dec      (dec)
    );

    execute_stage u_execute_stage (
        .clk      (clk),
        .reset    (reset),
        .advance  (advance),
        .dec      (dec),
        .exe      (exe),
        .redirect (redirect),
        .wake     (wake),
        .halt     (halt)
    );

    result_stage u_result_stage (
        .clk          (clk),
        .reset        (reset),
        .advance      (advance),
        .exe          (exe),
        .wr_en        (wr_en),
        .wr_id        (wr_id),
        .wr_rd        (wr_rd),
        .wr_value     (wr_value),
        .retire       (retire),
        .retire_valid (retire_valid)
    );

endmodule

// ==== testbench/barrel_core_chk.sv ====
`timescale 1ns/1ps

module barrel_core_chk (
    input logic                clk,
    input logic                reset,
    input barrel_pkg::retire_t retire,
    input logic                retire_valid,
    input logic                retire_ready
);

    // ------------------------------------------------------------------------
    // retire port protocol
    // ------------------------------------------------------------------------

    // record and valid hold until the consumer takes them
    property hold_on_stall;
        @(posedge clk) disable iff (reset)
            (retire_valid && !retire_ready) |=> (retire_valid && $stable(retire));
    endproperty

    a_hold_on_stall: assert property (hold_on_stall)
        else $error("retire record changed while stalled");

    a_reset_clears: assert property (@(posedge clk) reset |=> !retire_valid)
        else $error("retire_valid high during or right after reset");

    // r0 is never a write target
    a_no_r0_write: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> !(retire.wb_en && retire.rd == '0))
        else $error("retire record writes register 0");

endmodule

bind barrel_core barrel_core_chk u_barrel_core_chk (
    .clk          (clk),
    .reset        (reset),
    .retire       (retire),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready)
);

// ==== testbench/barrel_core_tb.sv ====
`timescale 1ns/1ps

module barrel_core_tb;

    localparam int rec_max = 64;

    logic                    clk;
    logic                    reset;
    logic                    load_valid;
    barrel_pkg::imem_addr_t  load_addr;
    barrel_pkg::word_t       load_data;
    barrel_pkg::thread_ctl_t start_req;
    barrel_pkg::retire_t     retire;
    logic                    retire_valid;
    logic                    retire_ready;

    // program image and expected retire sequence per thread
    barrel_pkg::word_t   prog [barrel_pkg::imem_words];
    barrel_pkg::retire_t exp_rec [barrel_pkg::threads][rec_max];
    int                  exp_len [barrel_pkg::threads];
    int                  got_len [barrel_pkg::threads];
    logic [barrel_pkg::threads-1:0] active;

    int unsigned lcg_state = 89891;
    bit          random_ready = 1'b0;
    int          mismatches = 0;
    int          other_errors = 0;
    int          checked = 0;
    int          cycles = 0;
    int          budget = 400;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    barrel_core u_barrel_core (
        .clk          (clk),
        .reset        (reset),
        .load_valid   (load_valid),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .start_req    (start_req),
        .retire       (retire),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready)
    );

    // ------------------------------------------------------------------------
    // instruction encoding and program image
    // ------------------------------------------------------------------------

    // opcode, rd, rs1, rs2 from the top down
    function automatic barrel_pkg::word_t r_word(input barrel_pkg::opcode_e op,
                                                 input int rd, input int rs1, input int rs2);
        return {op, 3'(rd), 3'(rs1), 3'(rs2), 19'd0};
    endfunction

    // 19-bit immediate in the low bits
    function automatic barrel_pkg::word_t i_word(input barrel_pkg::opcode_e op,
                                                 input int rd, input int rs1, input int imm);
        return {op, 3'(rd), 3'(rs1), 3'b000, 19'(imm)};
    endfunction

    function automatic logic next_ready();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return ((lcg_state >> 16) % 4) != 0;
    endfunction

    // unused words halt and carry their address in the immediate
    task automatic fill_program();
        for (int i = 0; i < barrel_pkg::imem_words; i++) begin
            prog[i] = {4'h8, 20'h00000, 8'(i)};
        end
    endtask

    task automatic place(input int t, input int idx, input barrel_pkg::word_t w);
        prog[t * 64 + idx] = w;
    endtask

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------

    task automatic model_thread(input int t);
        barrel_pkg::word_t   regs [barrel_pkg::reg_count];
        barrel_pkg::pc_t     pc;
        barrel_pkg::word_t   w;
        barrel_pkg::word_t   a;
        barrel_pkg::word_t   b;
        barrel_pkg::word_t   imm;
        barrel_pkg::retire_t r;
        logic [3:0]          op;
        bit                  stop;

        for (int i = 0; i < barrel_pkg::reg_count; i++) begin
            regs[i] = '0;
        end
        pc = t * 256;
        stop = 1'b0;
        while (!stop && exp_len[t] < rec_max) begin
            w   = prog[pc[9:2]];
            op  = w[31:28];
            a   = regs[w[24:22]];
            b   = regs[w[21:19]];
            imm = {{13{w[18]}}, w[18:0]};
            r          = '0;
            r.id       = 2'(t);
            r.pc       = pc;
            r.opcode   = barrel_pkg::opcode_e'(op);
            r.rd       = w[27:25];
            r.valid    = 1'b1;
            pc = pc + 4;
            case (op)
                4'h0: r.value = a + b;
                4'h1: r.value = a - b;
                4'h2: r.value = a & b;
                4'h3: r.value = a | b;
                4'h4: r.value = a ^ b;
                4'h5: r.value = a + imm;
                4'h6: r.value = {w[18:0], 13'd0};
                4'h7: begin
                    // value reports the next pc of the thread
                    r.taken = (a != '0);
                    if (r.taken) begin
                        pc = r.pc + (imm << 2);
                    end
                    r.value = pc;
                end
                4'h8: stop = 1'b1;
                4'h9: active[imm[1:0]] = 1'b1;
                default: begin
                end
            endcase
            r.wb_en = (op <= 4'h6) && (r.rd != '0);
            if (r.wb_en) begin
                regs[r.rd] = r.value;
            end
            exp_rec[t][exp_len[t]] = r;
            exp_len[t]++;
        end
    endtask

    // woken threads join the set until nothing new appears
    task automatic build_expected();
        logic [barrel_pkg::threads-1:0] modeled;
        bit                             progress;

        modeled = '0;
        for (int t = 0; t < barrel_pkg::threads; t++) begin
            exp_len[t] = 0;
            got_len[t] = 0;
        end
        progress = 1'b1;
        while (progress) begin
            progress = 1'b0;
            for (int t = 0; t < barrel_pkg::threads; t++) begin
                if (active[t] && !modeled[t]) begin
                    model_thread(t);
                    modeled[t] = 1'b1;
                    progress = 1'b1;
                end
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // drive and check
    // ------------------------------------------------------------------------

    task automatic reset_core();
        @(posedge clk);
        reset <= 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic load_program();
        for (int i = 0; i < barrel_pkg::imem_words; i++) begin
            @(posedge clk);
            load_valid <= 1'b1;
            load_addr  <= 8'(i);
            load_data  <= prog[i];
        end
        @(posedge clk);
        load_valid <= 1'b0;
    endtask

    task automatic check_record(input string name);
        int                  t;
        barrel_pkg::retire_t exp;

        t = int'(retire.id);
        assert (got_len[t] < exp_len[t]) else begin
            $display("%s: thread %0d retired pc %h beyond its expected sequence",
                     name, t, retire.pc);
            other_errors++;
        end
        if (got_len[t] < exp_len[t]) begin
            exp = exp_rec[t][got_len[t]];
            checked++;
            assert (retire == exp) else begin
                $display("[FAIL] %s thread %0d record %0d: expected %h, actual %h",
                         name, t, got_len[t], exp, retire);
                mismatches++;
            end
            got_len[t]++;
        end
    endtask

    task automatic run_case(input string name, input logic [3:0] mask);
        int total;
        int step;
        bit done;

        budget += 300;
        reset_core();
        load_program();
        active = mask;
        build_expected();
        total = 0;
        for (int t = 0; t < barrel_pkg::threads; t++) begin
            total += exp_len[t];
        end
        budget += 200 * total + 50;
        $display("%s: %0d records expected", name, total);

        step = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            // one start pulse per thread in the first slots
            start_req.id    <= 2'(step);
            start_req.valid <= (step < barrel_pkg::threads) && mask[step % 4];
            retire_ready    <= random_ready ? next_ready() : 1'b1;
            step++;
            @(negedge clk);
            if (retire_valid && retire_ready) begin
                check_record(name);
            end
            done = 1'b1;
            for (int t = 0; t < barrel_pkg::threads; t++) begin
                if (got_len[t] < exp_len[t]) begin
                    done = 1'b0;
                end
            end
        end

        // nothing may follow the last halt
        repeat (16) begin
            @(posedge clk);
            start_req.valid <= 1'b0;
            retire_ready    <= 1'b1;
            @(negedge clk);
            assert (!(retire_valid && retire_ready)) else begin
                $display("%s: extra record from thread %0d at pc %h after all halts",
                         name, retire.id, retire.pc);
                other_errors++;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------

    task automatic alu_registers();
        fill_program();
        place(0, 0, i_word(barrel_pkg::op_addi, 1, 0, 25));
        place(0, 1, i_word(barrel_pkg::op_addi, 2, 0, 12));
        place(0, 2, r_word(barrel_pkg::op_add, 3, 1, 2));
        place(0, 3, r_word(barrel_pkg::op_sub, 4, 2, 1));
        place(0, 4, r_word(barrel_pkg::op_and, 5, 1, 2));
        place(0, 5, r_word(barrel_pkg::op_or, 6, 1, 2));
        place(0, 6, r_word(barrel_pkg::op_xor, 7, 3, 4));
        // r0 target must stay zero
        place(0, 7, r_word(barrel_pkg::op_add, 0, 1, 2));
        place(0, 8, r_word(barrel_pkg::op_or, 1, 0, 7));
        place(0, 9, r_word(barrel_pkg::op_halt, 0, 0, 0));
        run_case("alu_registers", 4'b0001);
    endtask

    task automatic immediate_forms();
        fill_program();
        place(0, 0, i_word(barrel_pkg::op_addi, 1, 0, -5));
        place(0, 1, i_word(barrel_pkg::op_addi, 2, 1, -200000));
        place(0, 2, i_word(barrel_pkg::op_lui, 3, 0, 'h5a5a5));
        place(0, 3, i_word(barrel_pkg::op_lui, 4, 0, -1));
        place(0, 4, i_word(barrel_pkg::op_addi, 5, 3, 'h3ffff));
        place(0, 5, r_word(barrel_pkg::op_xor, 6, 5, 4));
        place(0, 6, r_word(barrel_pkg::op_halt, 0, 0, 0));
        run_case("immediate_forms", 4'b0001);
    endtask

    task automatic branch_countdown();
        fill_program();
        place(0, 0, i_word(barrel_pkg::op_addi, 1, 0, 5));
        place(0, 1, i_word(barrel_pkg::op_addi, 2, 2, 3));
        place(0, 2, i_word(barrel_pkg::op_addi, 1, 1, -1));
        place(0, 3, i_word(barrel_pkg::op_bnz, 0, 1, -2));
        // fall-through only once the count hits zero
        place(0, 4, i_word(barrel_pkg::op_addi, 3, 0, 77));
        place(0, 5, r_word(barrel_pkg::op_halt, 0, 0, 0));
        run_case("branch_countdown", 4'b0001);
    endtask

    task automatic halt_and_wake();
        fill_program();
        place(0, 0, i_word(barrel_pkg::op_addi, 1, 0, 9));
        place(0, 1, i_word(barrel_pkg::op_wake, 0, 0, 2));
        place(0, 2, r_word(barrel_pkg::op_halt, 0, 0, 0));
        place(0, 3, i_word(barrel_pkg::op_addi, 1, 0, 1));
        place(2, 0, i_word(barrel_pkg::op_addi, 1, 0, 40));
        place(2, 1, i_word(barrel_pkg::op_addi, 2, 1, 2));
        place(2, 2, r_word(barrel_pkg::op_halt, 0, 0, 0));
        place(2, 3, i_word(barrel_pkg::op_addi, 3, 0, 1));
        run_case("halt_and_wake", 4'b0001);
    endtask

    // each thread counts down from its own start value
    task automatic write_thread_programs();
        fill_program();
        for (int t = 0; t < barrel_pkg::threads; t++) begin
            place(t, 0, i_word(barrel_pkg::op_addi, 1, 0, t + 2));
            place(t, 1, i_word(barrel_pkg::op_lui, 2, 0, 'h100 + 'h11 * t));
            place(t, 2, r_word(barrel_pkg::op_add, 3, 3, 1));
            place(t, 3, i_word(barrel_pkg::op_addi, 1, 1, -1));
            place(t, 4, i_word(barrel_pkg::op_bnz, 0, 1, -2));
            place(t, 5, r_word(barrel_pkg::op_xor, 4, 3, 2));
            place(t, 6, r_word(barrel_pkg::op_sub, 5, 2, 3));
            place(t, 7, r_word(barrel_pkg::op_halt, 0, 0, 0));
        end
    endtask

    task automatic four_threads();
        write_thread_programs();
        random_ready = 1'b0;
        run_case("four_threads", 4'b1111);
    endtask

    task automatic ready_stall();
        write_thread_programs();
        random_ready = 1'b1;
        run_case("ready_stall", 4'b1111);
        random_ready = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------------------

    initial begin
        reset        = 1'b1;
        load_valid   = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        start_req    = '0;
        retire_ready = 1'b1;
        active       = '0;
        alu_registers();
        immediate_forms();
        branch_countdown();
        halt_and_wake();
        four_threads();
        ready_stall();
        $display("errors: %0d mismatches, %0d other, %0d records checked",
                 mismatches, other_errors, checked);
        if (mismatches == 0 && other_errors == 0 && checked > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        while (cycles <= budget) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the core stopped retiring records", cycles);
        $display("errors: %0d mismatches, %0d other, %0d records checked",
                 mismatches, other_errors, checked);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== all.f ====
hw/barrel_pkg.sv
hw/thread_pc.sv
hw/instr_mem.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/barrel_core.sv
testbench/barrel_core_chk.sv
testbench/barrel_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the barrel core testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module barrel_core_tb \
    -f all.f \
    -o barrel_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/barrel_core_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
echo "pass message not found"
exit 1
